/* Makefile */
TOP = tb_qr_capture

sim:
	verilator --binary --timing --assert -Wno-fatal -f qr_capture.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "RESULT: PASS"

clean:
	rm -rf obj_dir

.PHONY: sim clean

/* bit_frame_ram.sv */
`timescale 1ns/1ps

module bit_frame_ram
  import qr_capture_pkg::*;
#(
  parameter int DEPTH = FB_DEPTH
) (
  input  logic     clk_pixel,
  input  logic     wr_en,
  input  fb_addr_t wr_addr,
  input  logic     wr_bit,
  input  logic     rd_en,
  input  fb_addr_t rd_addr,
  output logic     rd_bit
);

  logic mem [DEPTH];  // one bit per stored pixel
  logic rd_stage;     // array output register

  // write port
  always_ff @(posedge clk_pixel) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_bit;
    end
  end

  // read port, two registers deep
  // same-address write is not seen until the next read (read-first)
  always_ff @(posedge clk_pixel) begin
    if (rd_en) begin
      rd_stage <= mem[rd_addr];
    end
    rd_bit <= rd_stage;  // output register, always enabled
  end

  // a writer address past the array would alias or be lost
  a_wr_in_range: assert property (@(posedge clk_pixel)
    wr_en |-> int'(wr_addr) < DEPTH);
  a_rd_in_range: assert property (@(posedge clk_pixel)
    rd_en |-> int'(rd_addr) < DEPTH);

endmodule

/* cam_pixel_assembler.sv */
`timescale 1ns/1ps

module cam_pixel_assembler
  import qr_capture_pkg::*;
(
  input  logic           clk_pixel,
  input  logic           sys_rst,
  input  cam_bus_t       cam,
  output located_pixel_t pixel
);

  cam_bus_t    cam_meta;   // first synchronizer stage
  cam_bus_t    cam_sync;   // second stage, safe to use
  logic        pclk_d;     // delayed copies for edge detection
  logic        href_d;
  logic        vsync_d;
  logic        pclk_rise;
  logic        href_fall;
  logic        vsync_rise;
  logic        take_byte;  // byte strobe
  logic        low_phase;  // high byte already held, next byte closes the pair
  logic [7:0]  high_byte;
  logic [10:0] col_cnt;
  logic [9:0]  row_cnt;
  logic        pix_valid;
  rgb565_t     pix_q;
  logic [10:0] col_q;
  logic [9:0]  row_q;

  always_ff @(posedge clk_pixel) begin
    if (sys_rst) begin
      cam_meta <= '0;
      cam_sync <= '0;
      pclk_d   <= 1'b0;
      href_d   <= 1'b0;
      vsync_d  <= 1'b0;
    end else begin
      cam_meta <= cam;
      cam_sync <= cam_meta;
      pclk_d   <= cam_sync.pclk;
      href_d   <= cam_sync.href;
      vsync_d  <= cam_sync.vsync;
    end
  end

  assign pclk_rise  = cam_sync.pclk & ~pclk_d;
  assign href_fall  = href_d & ~cam_sync.href;  // end of a line
  assign vsync_rise = cam_sync.vsync & ~vsync_d; // start of a new frame
  assign take_byte  = pclk_rise & cam_sync.href;

  // pairing state and position counters
  always_ff @(posedge clk_pixel) begin
    if (sys_rst) begin
      low_phase <= 1'b0;
      pix_valid <= 1'b0;
      col_cnt   <= '0;
      row_cnt   <= '0;
    end else begin
      pix_valid <= 1'b0;
      if (take_byte) begin
        low_phase <= ~low_phase;
        if (low_phase) begin
          pix_valid <= 1'b1;              // pixel leaves next cycle
          col_cnt   <= col_cnt + 11'd1;
        end
      end
      if (href_fall) begin
        low_phase <= 1'b0;                // realign pairs on every line
        col_cnt   <= '0;
        row_cnt   <= row_cnt + 10'd1;
      end
      if (vsync_rise) begin
        row_cnt <= '0;
      end
    end
  end

  // payload, first byte of the pair is the high byte
  always_ff @(posedge clk_pixel) begin
    if (take_byte && !low_phase) begin
      high_byte <= cam_sync.data;
    end
    if (take_byte && low_phase) begin
      pix_q <= rgb565_t'({high_byte, cam_sync.data});
      col_q <= col_cnt;  // position of this pixel, counter moves on
      row_q <= row_cnt;
    end
  end

  assign pixel = '{valid: pix_valid, pix: pix_q, col: col_q, row: row_q};

  // a camera line or frame longer than the counters can hold would wrap silently
  a_col_no_wrap: assert property (@(posedge clk_pixel) disable iff (sys_rst)
    take_byte && low_phase |-> col_cnt != 11'h7ff);
  a_row_no_wrap: assert property (@(posedge clk_pixel) disable iff (sys_rst)
    href_fall && !vsync_rise |-> row_cnt != 10'h3ff);

endmodule

/* frame_capture_writer.sv */
`timescale 1ns/1ps
`include "qr_capture_cfg.svh"

module frame_capture_writer
  import qr_capture_pkg::*;
(
  input  logic                    clk_pixel,
  input  logic                    sys_rst,
  input  located_pixel_t          pixel,
  input  logic [`QR_THRESH_W-1:0] threshold,
  input  logic                    hold,
  output logic                    wr_en,
  output fb_addr_t                wr_addr,
  output logic                    wr_bit
);

  localparam int LUMA_W = 8; // max 2*31 + 63 + 2*31 = 187

  logic [LUMA_W-1:0] luma;
  logic              is_light;   // binarized pixel
  logic              in_window;  // inside the stored window
  fb_addr_t          pix_addr;

  // cheap luma, red and blue doubled to match green's 6 bits
  assign luma = {2'b00, pixel.pix.red, 1'b0}
              + {2'b00, pixel.pix.green}
              + {2'b00, pixel.pix.blue, 1'b0};

  assign is_light = (luma >= threshold);

  // crop, columns past the window are dropped
  assign in_window = (pixel.col < `QR_STORED_W) && (pixel.row < `QR_STORED_H);

  // row-major address, only meaningful inside the window
  assign pix_addr = fb_addr_t'(pixel.row * `QR_STORED_W + pixel.col);

  always_ff @(posedge clk_pixel) begin
    if (sys_rst) begin
      wr_en <= 1'b0;
    end else begin
      wr_en <= pixel.valid && in_window && !hold; // hold freezes the buffer
    end
  end

  always_ff @(posedge clk_pixel) begin
    wr_addr <= pix_addr;
    wr_bit  <= is_light;
  end

endmodule

/* qr_capture.f */
+incdir+.
qr_capture_pkg.sv
cam_pixel_assembler.sv
frame_capture_writer.sv
bit_frame_ram.sv
scan_readout.sv
qr_capture_top.sv
tb_qr_capture.sv

/* qr_capture_cfg.svh */
`ifndef QR_CAPTURE_CFG_SVH
`define QR_CAPTURE_CFG_SVH

// camera line width in pixels, anything past the stored window is cropped
`define QR_CAM_W 20

// stored window, one bit per pixel in the frame buffer
`define QR_STORED_W 16
`define QR_STORED_H 16

// width of the binarization threshold from the switches
`define QR_THRESH_W 8

// sink buffer depth = credits held by the reader after reset
`define QR_CREDITS 4

`endif

/* qr_capture_pkg.sv */
package qr_capture_pkg;

  `include "qr_capture_cfg.svh"

  // raw parallel camera bus, asynchronous to clk_pixel
  typedef struct packed {
    logic       pclk;
    logic       vsync;
    logic       href;
    logic [7:0] data;
  } cam_bus_t;

  typedef struct packed {
    logic [4:0] red;
    logic [5:0] green;
    logic [4:0] blue;
  } rgb565_t;

  // pixel tagged with where it sits in the camera frame
  typedef struct packed {
    logic        valid; // one cycle per pixel
    rgb565_t     pix;
    logic [10:0] col;
    logic [9:0]  row;
  } located_pixel_t;

  localparam int FB_DEPTH = `QR_STORED_W * `QR_STORED_H;
  localparam int FB_AW    = $clog2(FB_DEPTH);
  localparam int X_W      = $clog2(`QR_STORED_W);
  localparam int Y_W      = $clog2(`QR_STORED_H);

  typedef logic [FB_AW-1:0] fb_addr_t;

  // one readout beat, pix_bit is the stored binarized pixel
  typedef struct packed {
    logic           pix_bit;
    logic           sof;     // set at x 0, y 0
    logic [X_W-1:0] x;
    logic [Y_W-1:0] y;
  } scan_beat_t;

endpackage

/* qr_capture_top.sv */
`timescale 1ns/1ps
`include "qr_capture_cfg.svh"

module qr_capture_top
  import qr_capture_pkg::*;
(
  input  logic                    clk_pixel,
  input  logic                    sys_rst,
  input  cam_bus_t                cam,
  input  logic [`QR_THRESH_W-1:0] threshold,
  input  logic                    hold,
  input  logic                    credit_return,
  output logic                    out_valid,
  output scan_beat_t              out_beat
);

  located_pixel_t pixel;   // assembler to writer
  logic           wr_en;   // writer to frame buffer
  fb_addr_t       wr_addr;
  logic           wr_bit;
  logic           rd_en;   // readout to frame buffer
  fb_addr_t       rd_addr;
  logic           rd_bit;

  cam_pixel_assembler u_assembler (
    .clk_pixel (clk_pixel),
    .sys_rst   (sys_rst),
    .cam       (cam),
    .pixel     (pixel)
  );

  frame_capture_writer u_writer (
    .clk_pixel (clk_pixel),
    .sys_rst   (sys_rst),
    .pixel     (pixel),
    .threshold (threshold),
    .hold      (hold),
    .wr_en     (wr_en),
    .wr_addr   (wr_addr),
    .wr_bit    (wr_bit)
  );

  bit_frame_ram #(.DEPTH(FB_DEPTH)) u_frame_ram (
    .clk_pixel (clk_pixel),
    .wr_en     (wr_en),
    .wr_addr   (wr_addr),
    .wr_bit    (wr_bit),
    .rd_en     (rd_en),
    .rd_addr   (rd_addr),
    .rd_bit    (rd_bit)
  );

  scan_readout u_readout (
    .clk_pixel     (clk_pixel),
    .sys_rst       (sys_rst),
    .hold          (hold),
    .credit_return (credit_return),
    .rd_en         (rd_en),
    .rd_addr       (rd_addr),
    .rd_bit        (rd_bit),
    .out_valid     (out_valid),
    .out_beat      (out_beat)
  );

endmodule

/* scan_readout.sv */
`timescale 1ns/1ps
`include "qr_capture_cfg.svh"

module scan_readout
  import qr_capture_pkg::*;
(
  input  logic       clk_pixel,
  input  logic       sys_rst,
  input  logic       hold,
  input  logic       credit_return,
  output logic       rd_en,
  output fb_addr_t   rd_addr,
  input  logic       rd_bit,
  output logic       out_valid,
  output scan_beat_t out_beat
);

  localparam int CREDIT_W = $clog2(`QR_CREDITS + 1);

  logic [CREDIT_W-1:0] credit_cnt;   // free slots in the sink
  fb_addr_t            raster_addr;  // next address to issue
  logic [1:0]          vld_pipe;     // tracks the ram's two-cycle latency
  fb_addr_t            addr_pipe [2];
  fb_addr_t            beat_addr;

  // one read per cycle while frozen, as long as the sink has room
  assign rd_en   = hold && (credit_cnt != '0);
  assign rd_addr = raster_addr;

  always_ff @(posedge clk_pixel) begin
    if (sys_rst) begin
      credit_cnt  <= CREDIT_W'(`QR_CREDITS);
      raster_addr <= '0;
      vld_pipe    <= '0;
    end else begin
      vld_pipe <= {vld_pipe[0], rd_en};
      // spend on issue, refund on return
      if (rd_en && !credit_return) begin
        credit_cnt <= credit_cnt - 1'b1;
      end else if (!rd_en && credit_return) begin
        credit_cnt <= credit_cnt + 1'b1;
      end
      // raster parks at 0 while hold is low, so a rising hold starts at the origin
      if (!hold) begin
        raster_addr <= '0;
      end else if (rd_en) begin
        raster_addr <= (raster_addr == fb_addr_t'(FB_DEPTH - 1)) ? '0 : raster_addr + 1'b1;
      end
    end
  end

  // coordinates ride alongside the ram read
  always_ff @(posedge clk_pixel) begin
    addr_pipe[0] <= rd_addr;
    addr_pipe[1] <= addr_pipe[0];
  end

  assign beat_addr = addr_pipe[1];
  assign out_valid = vld_pipe[1];  // in flight beats still drain after hold falls

  assign out_beat = '{
    pix_bit: rd_bit,
    sof:     (beat_addr == '0),
    x:       X_W'(beat_addr % `QR_STORED_W),
    y:       Y_W'(beat_addr / `QR_STORED_W)
  };

  // an issue on an empty count would wrap the counter to its top
  a_no_issue_empty: assert property (@(posedge clk_pixel) disable iff (sys_rst)
    rd_en && !credit_return |=> credit_cnt < $past(credit_cnt));
  // a return for a beat that was never sent would push past the sink depth
  a_credit_cap: assert property (@(posedge clk_pixel) disable iff (sys_rst)
    credit_cnt <= `QR_CREDITS);

endmodule

/* tb_qr_capture.sv */
`timescale 1ns/1ps
`include "qr_capture_cfg.svh"

module tb_qr_capture
  import qr_capture_pkg::*;
();

  localparam int CAM_H          = 18;          // camera lines per frame
  localparam int SEED           = 91856;
  localparam int TIMEOUT_CYCLES = 3 * CAM_H * `QR_CAM_W * 8 + 4 * FB_DEPTH * 4 + 2000;

  logic       clk_pixel;
  logic       sys_rst;
  cam_bus_t   cam;
  logic [7:0] threshold;
  logic       hold;
  logic       credit_return;
  logic       out_valid;
  scan_beat_t out_beat;

  logic        exp_bits [FB_DEPTH];    // reference frame from the luma rule
  logic        first_pass [FB_DEPTH];  // bits of the first raster pass after a hold rise
  fb_addr_t    exp_pos;                // raster position of the next beat
  int          pass_cnt;
  int          beats_seen;
  int          held;                   // beats sitting in the sink
  int          credit_model;           // reader credits, rebuilt from the credit rule
  logic        issue_model;
  logic [1:0]  issue_d;                // issue history, two cycles of ram latency
  logic [1:0]  hold_d;
  logic        withhold;               // sink stops returning credits
  logic [31:0] cam_state;
  int          cycle_cnt;

  qr_capture_top dut (
    .clk_pixel     (clk_pixel),
    .sys_rst       (sys_rst),
    .cam           (cam),
    .threshold     (threshold),
    .hold          (hold),
    .credit_return (credit_return),
    .out_valid     (out_valid),
    .out_beat      (out_beat)
  );

  initial begin
    clk_pixel = 1'b0;
    forever #10 clk_pixel = ~clk_pixel;  // 20 ns period
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // 2*r + g + 2*b against the switch threshold
  function automatic logic light_bit(input logic [15:0] px, input logic [7:0] thr);
    int luma;
    luma = 2 * int'(px[15:11]) + int'(px[10:5]) + 2 * int'(px[4:0]);
    return luma >= int'(thr);
  endfunction

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("RESULT: FAIL");
    $fatal(1);
  endtask

  // inputs move 2 ns after the rising edge
  task automatic step_cycle();
    @(posedge clk_pixel);
    #2;
  endtask

  // pclk keeps running between lines and frames
  task automatic idle_pclk(input int periods);
    cam.href = 1'b0;
    repeat (periods) begin
      cam.pclk = 1'b0;
      step_cycle();
      step_cycle();
      cam.pclk = 1'b1;
      step_cycle();
      step_cycle();
    end
  endtask

  task automatic send_byte(input logic [7:0] b);
    cam.pclk = 1'b0;  // data changes on the falling half
    cam.href = 1'b1;
    cam.data = b;
    step_cycle();
    step_cycle();
    cam.pclk = 1'b1;  // camera samples here
    step_cycle();
    step_cycle();
  endtask

  // one frame of random pixels, the reference follows only while the buffer is open
  task automatic send_frame(input logic update);
    logic [15:0] px;
    cam.vsync = 1'b1;
    idle_pclk(2);
    cam.vsync = 1'b0;
    idle_pclk(2);
    for (int r = 0; r < CAM_H; r++) begin
      for (int c = 0; c < `QR_CAM_W; c++) begin
        cam_state = xorshift32(cam_state);
        px = cam_state[23:8];
        send_byte(px[15:8]);  // high byte first
        send_byte(px[7:0]);
        if (update && r < `QR_STORED_H && c < `QR_STORED_W) begin
          exp_bits[r * `QR_STORED_W + c] = light_bit(px, threshold);
        end
      end
      idle_pclk(2);  // href low ends the line
    end
  endtask

  task automatic wait_beats(input int target);
    while (beats_seen < target) begin
      step_cycle();
    end
  endtask

  assign issue_model = hold && (credit_model != 0);

  // sink side bookkeeping and expected raster position
  always @(posedge clk_pixel) begin
    if (sys_rst) begin
      held         <= 0;
      credit_model <= `QR_CREDITS;
      issue_d      <= '0;
      hold_d       <= '0;
      exp_pos      <= '0;
      pass_cnt     <= 0;
      beats_seen   <= 0;
    end else begin
      held         <= held + int'(out_valid) - int'(credit_return);
      credit_model <= credit_model - int'(issue_model) + int'(credit_return);
      issue_d      <= {issue_d[0], issue_model};
      hold_d       <= {hold_d[0], hold};
      if (out_valid) begin
        beats_seen <= beats_seen + 1;
        if (pass_cnt == 0) begin
          first_pass[exp_pos] <= out_beat.pix_bit;
        end
        if (exp_pos == fb_addr_t'(FB_DEPTH - 1)) begin
          exp_pos  <= '0;
          pass_cnt <= pass_cnt + 1;
        end else begin
          exp_pos <= exp_pos + 1'b1;
        end
      end else if (!hold) begin
        exp_pos  <= '0;  // next hold rise starts at the origin
        pass_cnt <= 0;
      end
    end
  end

  // sink returns one credit per held beat after a random pause
  initial begin
    int          pause;
    logic        stall;
    logic [31:0] sink_state;
    credit_return = 1'b0;
    sink_state    = SEED;
    pause         = 0;
    forever begin
      @(posedge clk_pixel);
      stall = withhold;  // sampled on the edge, main drives it later
      #2;
      credit_return = 1'b0;
      if (pause > 0) begin
        pause--;
      end else if (held > 0 && !stall) begin
        credit_return = 1'b1;
        sink_state    = xorshift32(sink_state);
        pause         = int'(sink_state[17:16]);
      end
    end
  end

  always @(posedge clk_pixel) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == TIMEOUT_CYCLES) begin
      fail_run($sformatf("timeout after %0d cycles, the readout never finished", cycle_cnt));
    end
  end

  a_quiet_when_open: assert property (@(posedge clk_pixel) disable iff (sys_rst)
    !hold_d[1] |-> !out_valid)
    else fail_run($sformatf("MISMATCH time=%0t signal=out_valid got=%0b expected=0",
                            $time, $sampled(out_valid)));

  // beat exactly two cycles after an allowed issue, nothing otherwise
  a_credit_flow: assert property (@(posedge clk_pixel) disable iff (sys_rst)
    out_valid == issue_d[1])
    else fail_run($sformatf("MISMATCH time=%0t signal=out_valid got=%0b expected=%0b",
                            $time, $sampled(out_valid), $sampled(issue_d[1])));

  a_sink_room: assert property (@(posedge clk_pixel) disable iff (sys_rst)
    out_valid |-> held < `QR_CREDITS)
    else fail_run($sformatf("a beat arrived at %0t while the sink already held %0d beats",
                            $time, $sampled(held)));

  a_beat_x: assert property (@(posedge clk_pixel) disable iff (sys_rst)
    out_valid |-> out_beat.x == X_W'(int'(exp_pos) % `QR_STORED_W))
    else fail_run($sformatf("MISMATCH time=%0t signal=out_beat.x got=%0d expected=%0d",
                            $time, $sampled(out_beat.x),
                            int'($sampled(exp_pos)) % `QR_STORED_W));

  a_beat_y: assert property (@(posedge clk_pixel) disable iff (sys_rst)
    out_valid |-> out_beat.y == Y_W'(int'(exp_pos) / `QR_STORED_W))
    else fail_run($sformatf("MISMATCH time=%0t signal=out_beat.y got=%0d expected=%0d",
                            $time, $sampled(out_beat.y),
                            int'($sampled(exp_pos)) / `QR_STORED_W));

  a_beat_sof: assert property (@(posedge clk_pixel) disable iff (sys_rst)
    out_valid |-> out_beat.sof == (exp_pos == '0))
    else fail_run($sformatf("MISMATCH time=%0t signal=out_beat.sof got=%0b expected=%0b",
                            $time, $sampled(out_beat.sof), $sampled(exp_pos) == '0));

  a_beat_bit: assert property (@(posedge clk_pixel) disable iff (sys_rst)
    out_valid |-> out_beat.pix_bit == exp_bits[exp_pos])
    else fail_run($sformatf("MISMATCH time=%0t signal=out_beat.pix_bit got=%0b expected=%0b",
                            $time, $sampled(out_beat.pix_bit), exp_bits[$sampled(exp_pos)]));

  // frozen buffer, every later pass repeats the first one
  a_pass_repeat: assert property (@(posedge clk_pixel) disable iff (sys_rst)
    out_valid && pass_cnt != 0 |-> out_beat.pix_bit == first_pass[exp_pos])
    else fail_run($sformatf("MISMATCH time=%0t signal=out_beat.pix_bit got=%0b expected=%0b",
                            $time, $sampled(out_beat.pix_bit), first_pass[$sampled(exp_pos)]));

  initial begin
    int start;
    sys_rst   = 1'b1;
    cam       = '0;
    threshold = 8'd90;
    hold      = 1'b0;
    withhold  = 1'b0;
    cam_state = SEED;
    cycle_cnt = 0;
    repeat (5) @(posedge clk_pixel);
    #2;
    sys_rst = 1'b0;
    idle_pclk(4);

    send_frame(1'b1);  // buffer open, readout must stay silent
    idle_pclk(4);      // let the last writes land

    hold = 1'b1;
    wait_beats(64);
    withhold = 1'b1;   // sink fills up, issuing has to stall
    repeat (24) step_cycle();
    withhold = 1'b0;

    send_frame(1'b0);  // ignored while frozen
    wait_beats(2 * FB_DEPTH);
    hold = 1'b0;
    idle_pclk(4);

    threshold = 8'd130;
    send_frame(1'b1);
    idle_pclk(4);
    start = beats_seen;
    hold  = 1'b1;
    wait_beats(start + FB_DEPTH);
    hold = 1'b0;
    idle_pclk(8);      // drain beats in flight and sink credits

    if (held != 0) begin
      fail_run($sformatf("readout ended with %0d beats left in the sink", held));
    end else begin
      $display("RESULT: PASS");
      $finish;
    end
  end

endmodule
